//--- project.f
verilog/mipsIsaPkg.sv
verilog/execPkg.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/aluCore.sv
verilog/mulDivUnit.sv
verilog/mipsExec.sv
test/mipsExec_chk.sv
test/execScoreboard.sv
test/tbMipsExec.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbMipsExec
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OBJDIR)

//--- test/tbMipsExec.sv
`timescale 1ns/1ps

module tbMipsExec;
    import mipsIsaPkg::*;

    localparam int readyTimeout = 100;

    logic    clk;
    logic    rstN;
    logic    instrValid;
    wordT    instr;
    logic    instrReady;
    logic    wbValid;
    regAddrT wbReg;
    wordT    wbData;
    int      errCount;
    // failures found here rather than in the scoreboard
    int      localErr;
    int      testErrStart;
    int      testsRun;
    int      testsFailed;
    int      stalls;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    mipsExec i_mipsExec (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrReady (instrReady),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    execScoreboard scoreboard (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrReady (instrReady),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .errCount   (errCount)
    );

    function automatic wordT rType(input functT fn, input int rs, input int rt, input int rd,
                                   input int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic wordT iType(input opcodeT op, input int rs, input int rt,
                                   input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic int randReg();
        return int'($urandom_range(31, 0));
    endfunction

    // edge values for sign and zero extension now and then
    function automatic logic [15:0] randImm();
        case ($urandom_range(5, 0))
            0: return 16'h0000;
            1: return 16'hffff;
            2: return 16'h8000;
            3: return 16'h7fff;
            default: return 16'($urandom);
        endcase
    endfunction

    function automatic wordT randAlu();
        int rs;
        int rt;
        int rd;
        rs = randReg();
        rt = randReg();
        rd = randReg();
        case ($urandom_range(19, 0))
            0:  return rType(fnSll, 0, rt, rd, randReg());
            1:  return rType(fnSrl, 0, rt, rd, randReg());
            2:  return rType(fnSra, 0, rt, rd, randReg());
            3:  return rType(fnSllv, rs, rt, rd, 0);
            4:  return rType(fnSrlv, rs, rt, rd, 0);
            5:  return rType(fnSrav, rs, rt, rd, 0);
            6:  return rType(fnAddu, rs, rt, rd, 0);
            7:  return rType(fnSubu, rs, rt, rd, 0);
            8:  return rType(fnAnd, rs, rt, rd, 0);
            9:  return rType(fnOr, rs, rt, rd, 0);
            10: return rType(fnXor, rs, rt, rd, 0);
            11: return rType(fnSlt, rs, rt, rd, 0);
            12: return rType(fnSltu, rs, rt, rd, 0);
            13: return iType(opAddiu, rs, rt, randImm());
            14: return iType(opSlti, rs, rt, randImm());
            15: return iType(opSltiu, rs, rt, randImm());
            16: return iType(opAndi, rs, rt, randImm());
            17: return iType(opOri, rs, rt, randImm());
            18: return iType(opXori, rs, rt, randImm());
            default: return iType(opLui, 0, rt, randImm());
        endcase
    endfunction

    // called at a falling edge and returns at the one after acceptance
    task automatic issue(input wordT w, output int stallCnt);
        logic ok;
        ok         = 1'b0;
        stallCnt   = 0;
        instrValid = 1'b1;
        instr      = w;
        while (!ok) begin
            // ready has settled by mid low phase
            #25;
            ok = instrReady;
            @(posedge clk);
            if (!ok) begin
                stallCnt++;
                if (stallCnt > readyTimeout) begin
                    $display("timeout: instruction %h never accepted", w);
                    $display("Simulation failed");
                    $finish;
                end
            end
            @(negedge clk);
        end
        instrValid = 1'b0;
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic startTest();
        testErrStart = errCount + localErr;
    endtask

    task automatic finishTest(input string name);
        int n;
        n = errCount + localErr - testErrStart;
        testsRun++;
        if (n > 0) begin
            testsFailed++;
        end
        $display("test %-16s %s (%0d errors)", name, (n > 0) ? "FAIL" : "ok", n);
    endtask

    // read every register back through a writeback
    task automatic readAllRegs();
        for (int r = 0; r < 32; r++) begin
            issue(rType(fnAddu, r, 0, r, 0), stalls);
        end
    endtask

    initial begin
        void'($urandom(40496));
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        localErr   = 0;
        testsRun   = 0;
        testsFailed = 0;
        @(negedge clk);
        applyReset();

        startTest();
        for (int r = 0; r < 32; r++) begin
            issue(iType(opLui, 0, r, 16'($urandom)), stalls);
            issue(iType(opOri, r, r, 16'($urandom)), stalls);
        end
        readAllRegs();
        finishTest("regSetup");

        startTest();
        for (int i = 0; i < 300; i++) begin
            issue(randAlu(), stalls);
        end
        finishTest("randomAlu");

        startTest();
        for (int i = 0; i < 12; i++) begin
            issue(rType(($urandom_range(1, 0) == 0) ? fnMult : fnMultu,
                randReg(), randReg(), 0, 0), stalls);
            issue(rType(fnMfhi, 0, 0, randReg(), 0), stalls);
            if (stalls == 0) begin
                $display("mfhi was not held back while the multiply ran");
                localErr++;
            end
            issue(rType(fnMflo, 0, 0, randReg(), 0), stalls);
        end
        finishTest("multiply");

        startTest();
        // most negative value and minus one
        issue(iType(opLui, 0, 30, 16'h8000), stalls);
        issue(iType(opAddiu, 0, 29, 16'hffff), stalls);
        for (int i = 0; i < 16; i++) begin
            issue(rType(($urandom_range(1, 0) == 0) ? fnDiv : fnDivu,
                ($urandom_range(3, 0) == 0) ? 30 : randReg(),
                ($urandom_range(3, 0) == 0) ? 0 : (($urandom_range(3, 0) == 0) ? 29 : randReg()),
                0, 0), stalls);
            issue(rType(fnMfhi, 0, 0, randReg(), 0), stalls);
            issue(rType(fnMflo, 0, 0, randReg(), 0), stalls);
        end
        finishTest("divide");

        startTest();
        issue(rType(fnDiv, randReg(), 29, 0, 0), stalls);
        for (int i = 0; i < 10; i++) begin
            issue(randAlu(), stalls);
            if (stalls != 0) begin
                $display("ALU instruction stalled behind a running divide");
                localErr++;
            end
        end
        issue(rType(fnMflo, 0, 0, 5, 0), stalls);
        issue(rType(fnMthi, randReg(), 0, 0, 0), stalls);
        issue(rType(fnMtlo, randReg(), 0, 0, 0), stalls);
        issue(rType(fnMfhi, 0, 0, 6, 0), stalls);
        issue(rType(fnMflo, 0, 0, 7, 0), stalls);
        finishTest("overlap");

        startTest();
        issue(rType(fnMultu, randReg(), randReg(), 0, 0), stalls);
        for (int i = 0; i < 20; i++) begin
            issue(randAlu(), stalls);
        end
        applyReset();
        // a HI read would still stall if the multiply survived reset
        instr = rType(fnMfhi, 0, 0, 1, 0);
        #25;
        if (!instrReady) begin
            $display("instrReady is low right after reset");
            localErr++;
        end
        @(negedge clk);
        readAllRegs();
        issue(rType(fnMfhi, 0, 0, 1, 0), stalls);
        issue(rType(fnMflo, 0, 0, 2, 0), stalls);
        finishTest("resetMidRun");

        // let the last writeback reach the scoreboard
        repeat (2) @(negedge clk);
        $display("tests run: %0d, tests failed: %0d, errors: %0d",
            testsRun, testsFailed, errCount + localErr);
        if ((errCount + localErr) == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- test/execScoreboard.sv
`timescale 1ns/1ps

module execScoreboard (
    input  logic                clk,
    input  logic                rstN,
    input  logic                instrValid,
    input  mipsIsaPkg::wordT    instr,
    input  logic                instrReady,
    input  logic                wbValid,
    input  mipsIsaPkg::regAddrT wbReg,
    input  mipsIsaPkg::wordT    wbData,
    output int                  errCount
);
    import mipsIsaPkg::*;

    // architectural state of the model
    wordT    regs [32];
    wordT    hiM;
    wordT    loM;
    // cycles left on a running mult or div
    int      busyCnt;
    // writeback due at the next edge
    logic    expValid;
    regAddrT expReg;
    wordT    expData;

    function automatic logic isMdInstr(input wordT w);
        functT fn;
        fn = functT'(w[5:0]);
        return (w[31:26] == 6'h00) &&
            (fn inside {fnMfhi, fnMflo, fnMthi, fnMtlo, fnMult, fnMultu, fnDiv, fnDivu});
    endfunction

    function void reportValue(input string sig, input wordT exp, input wordT act);
        $display("[ERROR] %0t: %s expected %h, got %h", $time, sig, exp, act);
        errCount++;
    endfunction

    // quotient truncates toward zero, remainder keeps dividend sign
    task automatic divide(input wordT a, input wordT b, input logic sg);
        wordT ma;
        wordT mb;
        wordT q;
        wordT r;
        if (b == '0) begin
            hiM = a;
            loM = (sg && a[31]) ? 32'd1 : 32'hffff_ffff;
        end else begin
            ma  = (sg && a[31]) ? -a : a;
            mb  = (sg && b[31]) ? -b : b;
            q   = ma / mb;
            r   = ma % mb;
            loM = (sg && (a[31] ^ b[31])) ? -q : q;
            hiM = (sg && a[31]) ? -r : r;
        end
    endtask

    task automatic execute(input wordT w);
        opcodeT      op;
        functT       fn;
        regAddrT     dst;
        wordT        a;
        wordT        b;
        wordT        sExt;
        wordT        zExt;
        wordT        res;
        logic        wr;
        logic [63:0] prod;
        op   = opcodeT'(w[31:26]);
        fn   = functT'(w[5:0]);
        a    = regs[w[25:21]];
        b    = regs[w[20:16]];
        sExt = {{16{w[15]}}, w[15:0]};
        zExt = {16'h0000, w[15:0]};
        dst  = w[20:16];
        res  = '0;
        wr   = 1'b1;
        case (op)
            opSpecial: begin
                dst = w[15:11];
                case (fn)
                    fnSll:  res = b << w[10:6];
                    fnSrl:  res = b >> w[10:6];
                    fnSra:  res = $signed(b) >>> w[10:6];
                    fnSllv: res = b << a[4:0];
                    fnSrlv: res = b >> a[4:0];
                    fnSrav: res = $signed(b) >>> a[4:0];
                    fnAddu: res = a + b;
                    fnSubu: res = a - b;
                    fnAnd:  res = a & b;
                    fnOr:   res = a | b;
                    fnXor:  res = a ^ b;
                    fnSlt:  res = {31'd0, $signed(a) < $signed(b)};
                    fnSltu: res = {31'd0, a < b};
                    fnMfhi: res = hiM;
                    fnMflo: res = loM;
                    fnMthi: begin
                        hiM = a;
                        wr  = 1'b0;
                    end
                    fnMtlo: begin
                        loM = a;
                        wr  = 1'b0;
                    end
                    fnMult, fnMultu: begin
                        if (fn == fnMult) begin
                            prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                        end else begin
                            prod = {32'd0, a} * {32'd0, b};
                        end
                        hiM     = prod[63:32];
                        loM     = prod[31:0];
                        busyCnt = 33;
                        wr      = 1'b0;
                    end
                    fnDiv, fnDivu: begin
                        divide(a, b, fn == fnDiv);
                        busyCnt = 33;
                        wr      = 1'b0;
                    end
                    default: wr = 1'b0;
                endcase
            end
            opAddiu: res = a + sExt;
            opSlti:  res = {31'd0, $signed(a) < $signed(sExt)};
            opSltiu: res = {31'd0, a < sExt};
            opAndi:  res = a & zExt;
            opOri:   res = a | zExt;
            opXori:  res = a ^ zExt;
            opLui:   res = {w[15:0], 16'h0000};
            default: wr = 1'b0;
        endcase
        // r0 stays zero and gives no writeback
        if (wr && (dst != '0)) begin
            regs[dst] = res;
            expValid  = 1'b1;
            expReg    = dst;
            expData   = res;
        end
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            hiM      = '0;
            loM      = '0;
            busyCnt  = 0;
            expValid = 1'b0;
        end else begin
            // result of the previous acceptance
            if (wbValid !== expValid) begin
                reportValue("wbValid", {31'd0, expValid}, {31'd0, wbValid});
            end else if (expValid) begin
                if (wbReg !== expReg) begin
                    reportValue("wbReg", {27'd0, expReg}, {27'd0, wbReg});
                end
                if (wbData !== expData) begin
                    reportValue("wbData", expData, wbData);
                end
            end
            expValid = 1'b0;
            // stall rule
            if (instrReady !== !((busyCnt > 0) && isMdInstr(instr))) begin
                reportValue("instrReady", {31'd0, !((busyCnt > 0) && isMdInstr(instr))},
                    {31'd0, instrReady});
            end
            if (busyCnt > 0) begin
                busyCnt--;
            end
            if (instrValid && instrReady) begin
                execute(instr);
            end
        end
    end

endmodule

//--- test/mipsExec_chk.sv
`timescale 1ns/1ps

module mipsExecChk (
    input logic                clk,
    input logic                rstN,
    input logic                busy,
    input logic                instrReady,
    input logic                wbValid,
    input mipsIsaPkg::regAddrT wbReg
);
    // length of the current busy run
    int busyLen;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busyLen <= 0;
        end else if (busy) begin
            busyLen <= busyLen + 1;
        end else begin
            busyLen <= 0;
        end
    end

    // nothing stalls while the mul/div unit is idle
    readyInIdle: assert property (@(posedge clk) disable iff (!rstN)
        !busy |-> instrReady)
        else $error("instrReady low while mul/div unit idle");

    // mult and div take 33 cycles
    busyLength: assert property (@(posedge clk) disable iff (!rstN)
        $fell(busy) |-> (busyLen == 33))
        else $error("mul/div busy for %0d cycles instead of 33", busyLen);

    noWbToR0: assert property (@(posedge clk) disable iff (!rstN)
        wbValid |-> (wbReg != 5'd0))
        else $error("writeback names r0");

endmodule

bind mipsExec mipsExecChk chkMipsExec (
    .clk        (clk),
    .rstN       (rstN),
    .busy       (mdBusy),
    .instrReady (instrReady),
    .wbValid    (wbValid),
    .wbReg      (wbReg)
);

//--- verilog/mipsExec.sv
`timescale 1ns/1ps

module mipsExec (
    input  logic                clk,
    input  logic                rstN,
    input  logic                instrValid,
    input  mipsIsaPkg::wordT    instr,
    output logic                instrReady,
    output logic                wbValid,
    output mipsIsaPkg::regAddrT wbReg,
    output mipsIsaPkg::wordT    wbData
);
    import mipsIsaPkg::*;
    import execPkg::*;

    logic    fire;
    regAddrT rsAddr;
    regAddrT rtAddr;
    regAddrT rdAddr;
    aluOpT   aluOp;
    srcBSelT srcBSel;
    logic    useHi;
    shamtT   shamt;
    immT     imm;
    logic    gprWrite;
    mdOpT    mdOp;
    wordT    rsData;
    wordT    rtData;
    wordT    hi;
    wordT    lo;
    logic    mdBusy;
    wordT    aluResult;
    // accepted instruction with a GPR result
    logic    gprCommit;

    assign gprCommit = fire && gprWrite;

    instrDecode i_instrDecode (
        .instr      (instr),
        .instrValid (instrValid),
        .mdBusy     (mdBusy),
        .instrReady (instrReady),
        .fire       (fire),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .rdAddr     (rdAddr),
        .aluOp      (aluOp),
        .srcBSel    (srcBSel),
        .useHi      (useHi),
        .shamt      (shamt),
        .imm        (imm),
        .gprWrite   (gprWrite),
        .mdOp       (mdOp)
    );

    // written at the acceptance edge so the new value is
    // visible in the wbValid cycle and to the next instruction
    regFile i_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .wrEn   (gprCommit),
        .wrAddr (rdAddr),
        .wrData (aluResult),
        .rsData (rsData),
        .rtData (rtData)
    );

    aluCore i_aluCore (
        .aluOp   (aluOp),
        .srcBSel (srcBSel),
        .useHi   (useHi),
        .rsData  (rsData),
        .rtData  (rtData),
        .imm     (imm),
        .shamt   (shamt),
        .hi      (hi),
        .lo      (lo),
        .result  (aluResult)
    );

    mulDivUnit i_mulDivUnit (
        .clk    (clk),
        .rstN   (rstN),
        .mdOp   (mdOp),
        .start  (fire),
        .rsData (rsData),
        .rtData (rtData),
        .busy   (mdBusy),
        .hi     (hi),
        .lo     (lo)
    );

    // writeback stage, one cycle after acceptance
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else begin
            wbValid <= gprCommit;
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= rdAddr;
        wbData <= aluResult;
    end

endmodule

//--- verilog/mulDivUnit.sv
`timescale 1ns/1ps

module mulDivUnit (
    input  logic             clk,
    input  logic             rstN,
    input  execPkg::mdOpT    mdOp,
    input  logic             start,
    input  mipsIsaPkg::wordT rsData,
    input  mipsIsaPkg::wordT rtData,
    output logic             busy,
    output mipsIsaPkg::wordT hi,
    output mipsIsaPkg::wordT lo
);
    import mipsIsaPkg::*;
    import execPkg::*;

    mdStateT     state;
    // 32 steps then one sign-fix cycle
    logic [5:0]  count;
    // mul: {partial product, multiplier}, div: {remainder, quotient}
    logic [63:0] acc;
    // multiplicand or divisor magnitude
    wordT        opB;
    logic        isDiv;
    // negate product or quotient at the end
    logic        negQ;
    // remainder follows dividend sign
    logic        negR;

    logic        signedOp;
    logic        longOp;
    logic        lastCycle;
    wordT        magA;
    wordT        magB;
    logic [32:0] mulSum;
    logic [32:0] divShift;
    logic [33:0] divDiff;
    logic [63:0] prodFix;

    assign signedOp  = (mdOp == mdMult) || (mdOp == mdDiv);
    assign longOp    = mdOp inside {mdMult, mdMultu, mdDiv, mdDivu};
    assign lastCycle = (count == 6'd32);

    // operand magnitudes for the signed forms
    assign magA = (signedOp && rsData[31]) ? -rsData : rsData;
    assign magB = (signedOp && rtData[31]) ? -rtData : rtData;

    // shift-add step
    assign mulSum = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, opB} : 33'd0);

    // restoring step, borrow in bit 33
    assign divShift = {acc[63:32], acc[31]};
    assign divDiff  = {1'b0, divShift} - {2'b00, opB};

    assign prodFix = negQ ? -acc : acc;

    assign busy = (state == mdBusy);

    // control, HI and LO
    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= mdIdle;
            count <= '0;
            hi    <= '0;
            lo    <= '0;
        end else begin
            case (state)
                mdIdle: begin
                    if (start) begin
                        case (mdOp)
                            mdMthi: hi <= rsData;
                            mdMtlo: lo <= rsData;
                            mdMult, mdMultu, mdDiv, mdDivu: begin
                                state <= mdBusy;
                                count <= '0;
                            end
                            default: ;
                        endcase
                    end
                end
                mdBusy: begin
                    if (lastCycle) begin
                        // sign fix and result write
                        state <= mdIdle;
                        if (isDiv) begin
                            hi <= negR ? -acc[63:32] : acc[63:32];
                            lo <= negQ ? -acc[31:0] : acc[31:0];
                        end else begin
                            hi <= prodFix[63:32];
                            lo <= prodFix[31:0];
                        end
                    end else begin
                        count <= count + 6'd1;
                    end
                end
                default: state <= mdIdle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if ((state == mdIdle) && start && longOp) begin
            isDiv <= (mdOp == mdDiv) || (mdOp == mdDivu);
            // product and quotient share the sign rule
            negQ  <= signedOp && (rsData[31] ^ rtData[31]);
            negR  <= signedOp && rsData[31];
            opB   <= magB;
            acc   <= {32'd0, magA};
        end else if (busy && !lastCycle) begin
            if (!isDiv) begin
                acc <= {mulSum, acc[31:1]};
            end else if (!divDiff[33]) begin
                // divisor fits, quotient bit 1
                acc <= {divDiff[31:0], acc[30:0], 1'b1};
            end else begin
                acc <= {divShift[31:0], acc[30:0], 1'b0};
            end
        end
    end

endmodule

//--- verilog/aluCore.sv
`timescale 1ns/1ps

module aluCore (
    input  execPkg::aluOpT    aluOp,
    input  execPkg::srcBSelT  srcBSel,
    input  logic              useHi,
    input  mipsIsaPkg::wordT  rsData,
    input  mipsIsaPkg::wordT  rtData,
    input  mipsIsaPkg::immT   imm,
    input  mipsIsaPkg::shamtT shamt,
    input  mipsIsaPkg::wordT  hi,
    input  mipsIsaPkg::wordT  lo,
    output mipsIsaPkg::wordT  result
);
    import mipsIsaPkg::*;
    import execPkg::*;

    wordT  opB;
    shamtT shiftAmt;

    // operand B mux
    always_comb begin
        case (srcBSel)
            srcSignImm: opB = {{16{imm[15]}}, imm};
            srcZeroImm: opB = {16'h0000, imm};
            srcHiLo:    opB = useHi ? hi : lo;
            default:    opB = rtData;
        endcase
    end

    // decoder zeroes whichever source is not in use
    assign shiftAmt = shamt | rsData[4:0];

    always_comb begin
        case (aluOp)
            aluAdd:  result = rsData + opB;
            aluSub:  result = rsData - opB;
            aluAnd:  result = rsData & opB;
            aluOr:   result = rsData | opB;
            aluXor:  result = rsData ^ opB;
            // shifts act on rt, which arrives as operand B
            aluSll:  result = opB << shiftAmt;
            aluSrl:  result = opB >> shiftAmt;
            aluSra:  result = $signed(opB) >>> shiftAmt;
            // compares give 0 or 1
            aluSlt:  result = {31'd0, $signed(rsData) < $signed(opB)};
            aluSltu: result = {31'd0, rsData < opB};
            aluLui:  result = {imm, 16'h0000};
            aluPassB: result = opB;
            default: result = '0;
        endcase
    end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                clk,
    input  logic                rstN,
    input  mipsIsaPkg::regAddrT rsAddr,
    input  mipsIsaPkg::regAddrT rtAddr,
    input  logic                wrEn,
    input  mipsIsaPkg::regAddrT wrAddr,
    input  mipsIsaPkg::wordT    wrData,
    output mipsIsaPkg::wordT    rsData,
    output mipsIsaPkg::wordT    rtData
);
    import mipsIsaPkg::*;

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            // r0 never stored
            regs[wrAddr] <= wrData;
        end
    end

    // read ports, r0 forced to zero
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

//--- verilog/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
    input  mipsIsaPkg::wordT    instr,
    input  logic                instrValid,
    input  logic                mdBusy,
    output logic                instrReady,
    output logic                fire,
    output mipsIsaPkg::regAddrT rsAddr,
    output mipsIsaPkg::regAddrT rtAddr,
    output mipsIsaPkg::regAddrT rdAddr,
    output execPkg::aluOpT      aluOp,
    output execPkg::srcBSelT    srcBSel,
    output logic                useHi,
    output mipsIsaPkg::shamtT   shamt,
    output mipsIsaPkg::immT     imm,
    output logic                gprWrite,
    output execPkg::mdOpT       mdOp
);
    import mipsIsaPkg::*;
    import execPkg::*;

    opcodeT opcode;
    functT  funct;
    // instruction writes a GPR at all
    logic   writes;
    // instruction touches HI/LO or the mul/div unit
    logic   isMd;
    // fixed shifts take shamt, variable shifts take rs[4:0]
    logic   fixedShift;
    logic   varShift;

    assign opcode = opcodeT'(instr[31:26]);
    assign funct  = functT'(instr[5:0]);
    assign rtAddr = instr[20:16];
    assign imm    = instr[15:0];

    always_comb begin
        aluOp      = aluAdd;
        srcBSel    = srcRt;
        useHi      = 1'b0;
        mdOp       = mdNone;
        writes     = 1'b1;
        isMd       = 1'b0;
        fixedShift = 1'b0;
        varShift   = 1'b0;
        // immediate forms write rt
        rdAddr     = instr[20:16];
        case (opcode)
            opSpecial: begin
                rdAddr = instr[15:11];
                case (funct)
                    fnSll:  begin aluOp = aluSll;  fixedShift = 1'b1; end
                    fnSrl:  begin aluOp = aluSrl;  fixedShift = 1'b1; end
                    fnSra:  begin aluOp = aluSra;  fixedShift = 1'b1; end
                    fnSllv: begin aluOp = aluSll;  varShift = 1'b1;   end
                    fnSrlv: begin aluOp = aluSrl;  varShift = 1'b1;   end
                    fnSrav: begin aluOp = aluSra;  varShift = 1'b1;   end
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnSlt:  aluOp = aluSlt;
                    fnSltu: aluOp = aluSltu;
                    fnMfhi, fnMflo: begin
                        aluOp   = aluPassB;
                        srcBSel = srcHiLo;
                        useHi   = (funct == fnMfhi);
                        isMd    = 1'b1;
                    end
                    fnMthi: begin mdOp = mdMthi;  writes = 1'b0; isMd = 1'b1; end
                    fnMtlo: begin mdOp = mdMtlo;  writes = 1'b0; isMd = 1'b1; end
                    fnMult: begin mdOp = mdMult;  writes = 1'b0; isMd = 1'b1; end
                    fnMultu: begin mdOp = mdMultu; writes = 1'b0; isMd = 1'b1; end
                    fnDiv:  begin mdOp = mdDiv;   writes = 1'b0; isMd = 1'b1; end
                    fnDivu: begin mdOp = mdDivu;  writes = 1'b0; isMd = 1'b1; end
                    // unknown function, no effect
                    default: writes = 1'b0;
                endcase
            end
            opAddiu: srcBSel = srcSignImm;
            opSlti: begin
                aluOp   = aluSlt;
                srcBSel = srcSignImm;
            end
            // sltiu still sign-extends, compare is unsigned
            opSltiu: begin
                aluOp   = aluSltu;
                srcBSel = srcSignImm;
            end
            opAndi: begin
                aluOp   = aluAnd;
                srcBSel = srcZeroImm;
            end
            opOri: begin
                aluOp   = aluOr;
                srcBSel = srcZeroImm;
            end
            opXori: begin
                aluOp   = aluXor;
                srcBSel = srcZeroImm;
            end
            opLui: aluOp = aluLui;
            default: writes = 1'b0;
        endcase
    end

    // ALU ORs shamt with rs[4:0], so zero out the unused one
    assign rsAddr = fixedShift ? '0 : instr[25:21];
    assign shamt  = varShift ? '0 : instr[10:6];

    // r0 is never a real destination
    assign gprWrite = writes && (rdAddr != '0);

    // HI/LO users wait for a running mul/div
    assign instrReady = !(mdBusy && isMd);
    assign fire       = instrValid && instrReady;

endmodule

//--- verilog/execPkg.sv
package execPkg;

    // ALU function select
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu,
        aluLui,
        // forwards operand B, used by mfhi and mflo
        aluPassB
    } aluOpT;

    // commands to the mul/div unit
    typedef enum logic [2:0] {
        mdNone,
        mdMult,
        mdMultu,
        mdDiv,
        mdDivu,
        mdMthi,
        mdMtlo
    } mdOpT;

    typedef enum logic {
        mdIdle,
        mdBusy
    } mdStateT;

    // operand B source
    typedef enum logic [1:0] {
        srcRt,
        srcSignImm,
        srcZeroImm,
        srcHiLo
    } srcBSelT;

endpackage

//--- verilog/mipsIsaPkg.sv
package mipsIsaPkg;

    // data word and register file index
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // instruction fields
    typedef logic [4:0]  shamtT;
    typedef logic [15:0] immT;

    // primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opAddiu   = 6'h09,
        opSlti    = 6'h0a,
        opSltiu   = 6'h0b,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opXori    = 6'h0e,
        opLui     = 6'h0f
    } opcodeT;

    // special function codes, bits 5:0
    typedef enum logic [5:0] {
        fnSll   = 6'h00,
        fnSrl   = 6'h02,
        fnSra   = 6'h03,
        fnSllv  = 6'h04,
        fnSrlv  = 6'h06,
        fnSrav  = 6'h07,
        fnMfhi  = 6'h10,
        fnMthi  = 6'h11,
        fnMflo  = 6'h12,
        fnMtlo  = 6'h13,
        fnMult  = 6'h18,
        fnMultu = 6'h19,
        fnDiv   = 6'h1a,
        fnDivu  = 6'h1b,
        fnAddu  = 6'h21,
        fnSubu  = 6'h23,
        fnAnd   = 6'h24,
        fnOr    = 6'h25,
        fnXor   = 6'h26,
        fnSlt   = 6'h2a,
        fnSltu  = 6'h2b
    } functT;

endpackage
